//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
LFLAGS    = --lint-only -Wall --timing
TOP       = tb_pcie_reg_ack
FLIST     = flist.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) $(LFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)

//--- design/cpl_hdr_build.sv
// single dw completions only; byte count and low address come from first be, last be is ignored
module cpl_hdr_build (
    input  logic                    PCIE_CLK,
    input  logic                    PCIE_RST,
    input  pcie_cpl_pkg::cpl_req_t  req,             // captured request
    input  logic [31:0]             payload,         // swapped read data
    input  logic [15:0]             completer_id,    // our own id
    output pcie_cpl_pkg::cpl_beat_u sop_beat,        // dw1 | dw0
    output pcie_cpl_pkg::cpl_beat_u eop_beat         // data | dw2
);

    logic [2:0]            bcnt_q;                   // 1 to 4 bytes
    logic [6:0]            ladr_q;                   // addr[6:0] of first enabled byte
    pcie_cpl_pkg::cpl_dw0_t dw0;
    pcie_cpl_pkg::cpl_dw1_t dw1;
    pcie_cpl_pkg::cpl_dw2_t dw2;

    // ======================================================================
    // byte count and low address decode
    // ======================================================================
    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            bcnt_q <= 3'd0;
            ladr_q <= 7'd0;
        end else begin
            casez (req.be[3:0])                      // first match wins
                4'b1??1:                    bcnt_q <= 3'd4;
                4'b01?1, 4'b1?10:           bcnt_q <= 3'd3;
                4'b0011, 4'b0110, 4'b1100:  bcnt_q <= 3'd2;
                default:                    bcnt_q <= 3'd1;     // incl. zero length read
            endcase

            casez (req.be[3:0])                      // lowest enabled byte
                4'b??10: ladr_q <= {req.addr, 2'd1};
                4'b?100: ladr_q <= {req.addr, 2'd2};
                4'b1000: ladr_q <= {req.addr, 2'd3};
                default: ladr_q <= {req.addr, 2'd0}; // bit 0 set or 0000
            endcase
        end
    end

    // ======================================================================
    // header dws and beat words
    // ======================================================================
    always_comb begin
        dw0          = '0;                           // reserved bits stay zero
        dw0.fmt_type = pcie_cpl_pkg::cpl_fmt_type;
        dw0.tc       = req.tc;
        dw0.td       = req.td;
        dw0.ep       = req.ep;
        dw0.attr     = req.attr;
        dw0.len      = req.len;

        dw1.cpl_id   = completer_id;
        dw1.status   = pcie_cpl_pkg::cpl_status_sc;
        dw1.bcm      = 1'b0;
        dw1.byte_cnt = {9'd0, bcnt_q};

        dw2.rid      = req.rid;
        dw2.tag      = req.tag;
        dw2.rsvd0    = 1'b0;
        dw2.low_addr = ladr_q;

        sop_beat.sop.dw1  = dw1;                     // header beat
        sop_beat.sop.dw0  = dw0;
        eop_beat.eop.data = payload;                 // data beat
        eop_beat.eop.dw2  = dw2;
    end

endmodule

//--- design/cpl_req_capture.sv
// one read in flight; reg_rd_req must lead reg_rd_ack by 2 cycles, payload holds x until first ack
module cpl_req_capture (
    input  logic                    PCIE_CLK,
    input  logic                    PCIE_RST,
    input  logic                    reg_rd_req,      // request strobe, one cycle
    input  logic                    reg_rd_ack,      // read data strobe, one cycle
    input  pcie_cpl_pkg::cpl_rx_t   rx_req,          // loose core fields, packed
    input  logic [63:0]             reg_op_addr,     // request byte address
    input  logic [31:0]             reg_rd_data,     // register file read data
    output pcie_cpl_pkg::cpl_req_t  req,             // held request fields
    output logic [31:0]             payload          // byte swapped read data
);

    pcie_cpl_pkg::cpl_req_t req_q;
    logic [31:0]            payload_q;

    // ======================================================================
    // request fields
    // ======================================================================
    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            req_q <= '0;                                 // be and addr feed the decode
        end else if (reg_rd_req) begin
            req_q.tc   <= rx_req.tc;
            req_q.td   <= rx_req.td;
            req_q.ep   <= rx_req.ep;
            req_q.attr <= rx_req.attr;
            req_q.len  <= rx_req.len;
            req_q.rid  <= rx_req.rid;
            req_q.tag  <= rx_req.tag;
            req_q.be   <= rx_req.be;
            req_q.addr <= reg_op_addr[6:2];              // dw inside the window
        end
    end

    // ======================================================================
    // read data, little endian register to big endian tlp order
    // ======================================================================
    always_ff @(posedge PCIE_CLK) begin
        if (reg_rd_ack) begin
            payload_q <= {<<8{reg_rd_data}};             // byte 0 goes to [31:24]
        end
    end

    assign req     = req_q;
    assign payload = payload_q;

endmodule

//--- design/cpl_tx_seq.sv
// ACK_SYNC_STAGES must be 2 or more; cpk_tx_ack must be a one cycle pulse, one completion at a time
module cpl_tx_seq #(
    parameter int ACK_SYNC_STAGES = 2                // delay on both acknowledges
) (
    input  logic                    PCIE_CLK,
    input  logic                    PCIE_RST,
    input  logic                    reg_rd_ack,      // read data arrived
    input  logic                    cpk_tx_ack,      // transmit grant pulse
    input  pcie_cpl_pkg::cpl_beat_u sop_beat,
    input  pcie_cpl_pkg::cpl_beat_u eop_beat,
    output logic                    cpk_tx_req,      // held until granted
    output logic [63:0]             cpk_tx_data,
    output logic [1:0]              cpk_tx_mask,
    output logic                    cpk_tx_dvld,
    output logic                    cpk_tx_sop,
    output logic                    cpk_tx_eop,
    output logic                    reg_rd_ok        // completion sent, one cycle
);

    localparam int last_stage = ACK_SYNC_STAGES - 1;

    logic [ACK_SYNC_STAGES-1:0] rd_ack_sr;           // read ack delay line
    logic [ACK_SYNC_STAGES-1:0] tx_ack_sr;           // grant delay line
    logic                       tx_req_q;
    logic                       rd_ok_q;
    pcie_cpl_pkg::cpl_tx_t      tx_d;
    pcie_cpl_pkg::cpl_tx_t      tx_q;

    // ======================================================================
    // acknowledge delay lines
    // ======================================================================
    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            rd_ack_sr <= '0;
            tx_ack_sr <= '0;
        end else begin
            rd_ack_sr <= {rd_ack_sr[ACK_SYNC_STAGES-2:0], reg_rd_ack};
            tx_ack_sr <= {tx_ack_sr[ACK_SYNC_STAGES-2:0], cpk_tx_ack};
        end
    end

    // sticky request, set beats clear
    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            tx_req_q <= 1'b0;
        end else if (rd_ack_sr[last_stage]) begin
            tx_req_q <= 1'b1;
        end else if (tx_ack_sr[last_stage]) begin
            tx_req_q <= 1'b0;                        // cleared with the eop beat
        end
    end

    // ======================================================================
    // output beats
    // ======================================================================
    always_comb begin
        tx_d = '0;                                   // idle bus is all zero
        if (tx_ack_sr[0]) begin
            tx_d.dvld = 1'b1;
            tx_d.sop  = 1'b1;
            tx_d.mask = 2'b11;
            tx_d.data = sop_beat;                    // dw1 | dw0
        end else if (tx_ack_sr[last_stage]) begin
            tx_d.dvld = 1'b1;
            tx_d.eop  = 1'b1;
            tx_d.mask = 2'b11;
            tx_d.data = eop_beat;                    // payload | dw2
        end
    end

    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            tx_q    <= '0;
            rd_ok_q <= 1'b0;
        end else begin
            tx_q    <= tx_d;
            rd_ok_q <= tx_ack_sr[last_stage];        // lines up with eop
        end
    end

    assign cpk_tx_req  = tx_req_q;
    assign cpk_tx_data = tx_q.data;
    assign cpk_tx_mask = tx_q.mask;
    assign cpk_tx_dvld = tx_q.dvld;
    assign cpk_tx_sop  = tx_q.sop;
    assign cpk_tx_eop  = tx_q.eop;
    assign reg_rd_ok   = rd_ok_q;

endmodule

//--- design/pcie_cpl_pkg.sv
// completion types for single-DW register reads only; status is always success with bcm 0
package pcie_cpl_pkg;

    // ======================================================================
    // completion constants
    // ======================================================================
    localparam logic [6:0] cpl_fmt_type  = 7'b1001010;   // cpld, 3dw header with data
    localparam logic [2:0] cpl_status_sc = 3'b000;       // successful completion

    typedef logic [4:0] reg_addr_t;                      // dw address, request addr[6:2]

    // request fields as they arrive from the core, before the address is added
    typedef struct packed {
        logic [2:0]  tc;                                 // traffic class
        logic        td;                                 // digest present
        logic        ep;                                 // poisoned
        logic [1:0]  attr;                               // ordering attributes
        logic [9:0]  len;                                // length in dw
        logic [15:0] rid;                                // requester id
        logic [7:0]  tag;                                // requester tag
        logic [7:0]  be;                                 // last be [7:4], first be [3:0]
    } cpl_rx_t;                                          // 49 bits

    typedef struct packed {
        logic [2:0]  tc;
        logic        td;
        logic        ep;
        logic [1:0]  attr;
        logic [9:0]  len;
        logic [15:0] rid;
        logic [7:0]  tag;
        logic [7:0]  be;
        reg_addr_t   addr;                               // latched with the request
    } cpl_req_t;                                         // 54 bits

    // ======================================================================
    // completion header dws
    // ======================================================================
    typedef struct packed {
        logic        rsvd0;
        logic [6:0]  fmt_type;                           // cpl_fmt_type
        logic        rsvd1;
        logic [2:0]  tc;
        logic [3:0]  rsvd2;
        logic        td;
        logic        ep;
        logic [1:0]  attr;
        logic [1:0]  rsvd3;
        logic [9:0]  len;
    } cpl_dw0_t;

    typedef struct packed {
        logic [15:0] cpl_id;                             // completer id
        logic [2:0]  status;                             // completion status
        logic        bcm;                                // byte count modified
        logic [11:0] byte_cnt;                           // remaining bytes
    } cpl_dw1_t;

    typedef struct packed {
        logic [15:0] rid;
        logic [7:0]  tag;
        logic        rsvd0;
        logic [6:0]  low_addr;                           // byte address of first byte
    } cpl_dw2_t;

    // ======================================================================
    // transmit beat, one 64 bit word seen two ways
    // ======================================================================
    typedef struct packed {
        cpl_dw1_t    dw1;                                // upper half
        cpl_dw0_t    dw0;                                // lower half
    } cpl_sop_t;

    typedef struct packed {
        logic [31:0] data;                               // payload dw, byte swapped
        cpl_dw2_t    dw2;
    } cpl_eop_t;

    typedef union packed {
        cpl_sop_t    sop;                                // first beat
        cpl_eop_t    eop;                                // last beat
    } cpl_beat_u;

    // output register group of the transmit port
    typedef struct packed {
        logic        dvld;
        logic        sop;
        logic        eop;
        logic [1:0]  mask;                               // per dw valid
        logic [63:0] data;
    } cpl_tx_t;

endpackage

//--- design/pcie_reg_ack.sv
// one single-dw read at a time; the next reg_rd_req must wait for reg_rd_ok, status is always success
module pcie_reg_ack #(
    parameter int ACK_SYNC_STAGES = 2                // 2 or more
) (
    input  logic        PCIE_CLK,
    input  logic        PCIE_RST,                    // async, active high
    // register side
    input  logic        reg_rd_req,
    input  logic        reg_rd_ack,
    input  logic [31:0] reg_rd_data,
    input  logic [63:0] reg_op_addr,
    output logic        reg_rd_ok,
    // request fields from the core
    input  logic [2:0]  rx_tc,
    input  logic        rx_td,
    input  logic        rx_ep,
    input  logic [1:0]  rx_attr,
    input  logic [9:0]  rx_len,
    input  logic [15:0] rx_rid,
    input  logic [7:0]  rx_rtag,
    input  logic [7:0]  rx_be,
    input  logic [15:0] completer_id,
    // completion transmit
    output logic        cpk_tx_req,
    input  logic        cpk_tx_ack,
    output logic [63:0] cpk_tx_data,
    output logic [1:0]  cpk_tx_mask,
    output logic        cpk_tx_dvld,
    output logic        cpk_tx_sop,
    output logic        cpk_tx_eop
);

    pcie_cpl_pkg::cpl_rx_t   rx_req;
    pcie_cpl_pkg::cpl_req_t  req;
    logic [31:0]             payload;
    pcie_cpl_pkg::cpl_beat_u sop_beat;
    pcie_cpl_pkg::cpl_beat_u eop_beat;

    // core fields packed in header order
    assign rx_req = '{tc: rx_tc, td: rx_td, ep: rx_ep, attr: rx_attr, len: rx_len,
                      rid: rx_rid, tag: rx_rtag, be: rx_be};

    // ======================================================================
    // capture -> header -> transmit
    // ======================================================================
    cpl_req_capture u_capture (
        .PCIE_CLK    (PCIE_CLK),
        .PCIE_RST    (PCIE_RST),
        .reg_rd_req  (reg_rd_req),
        .reg_rd_ack  (reg_rd_ack),
        .rx_req      (rx_req),
        .reg_op_addr (reg_op_addr),
        .reg_rd_data (reg_rd_data),
        .req         (req),
        .payload     (payload)
    );

    cpl_hdr_build u_hdr (
        .PCIE_CLK     (PCIE_CLK),
        .PCIE_RST     (PCIE_RST),
        .req          (req),
        .payload      (payload),
        .completer_id (completer_id),
        .sop_beat     (sop_beat),
        .eop_beat     (eop_beat)
    );

    cpl_tx_seq #(
        .ACK_SYNC_STAGES (ACK_SYNC_STAGES)
    ) u_tx (
        .PCIE_CLK    (PCIE_CLK),
        .PCIE_RST    (PCIE_RST),
        .reg_rd_ack  (reg_rd_ack),
        .cpk_tx_ack  (cpk_tx_ack),
        .sop_beat    (sop_beat),
        .eop_beat    (eop_beat),
        .cpk_tx_req  (cpk_tx_req),
        .cpk_tx_data (cpk_tx_data),
        .cpk_tx_mask (cpk_tx_mask),
        .cpk_tx_dvld (cpk_tx_dvld),
        .cpk_tx_sop  (cpk_tx_sop),
        .cpk_tx_eop  (cpk_tx_eop),
        .reg_rd_ok   (reg_rd_ok)
    );

endmodule

//--- include/pcie_reg_ack_tests.svh
// included inside tb_pcie_reg_ack; every wait gives up after wait_limit cycles and counts an error
`ifndef PCIE_REG_ACK_TESTS_SVH
`define PCIE_REG_ACK_TESTS_SVH

localparam int wait_limit = 50;                      // cycles before a wait gives up

// ======================================================================
// stimulus and wait loops
// ======================================================================
task automatic issue_read(input string test, input logic [7:0] be, output bit ok);
    logic [31:0] r0;
    logic [31:0] r1;
    int          n;
    @(negedge PCIE_CLK);                             // gap after the last completion
    r0           = next_rand();
    r1           = next_rand();
    rx_rid       = r0[15:0];
    rx_rtag      = r0[23:16];
    rx_tc        = r0[26:24];
    rx_attr      = r0[28:27];
    rx_td        = r0[29];
    rx_ep        = r0[30];
    rx_len       = 10'd1;                            // single dw reads only
    rx_be        = be;
    completer_id = r1[15:0];
    reg_op_addr  = {next_rand(), next_rand()};
    reg_rd_data  = next_rand();
    reg_rd_req   = 1'b1;
    @(negedge PCIE_CLK);
    reg_rd_req   = 1'b0;
    repeat (2) @(negedge PCIE_CLK);                  // req leads ack by 2 cycles
    reg_rd_ack   = 1'b1;
    @(negedge PCIE_CLK);
    reg_rd_ack   = 1'b0;
    ok = 1'b0;
    for (n = 0; n < wait_limit && !ok; n++) begin
        @(negedge PCIE_CLK);
        ok = cpk_tx_req;
    end
    if (!ok) note_problem(test, "cpk_tx_req never rose after the read acknowledge");
endtask

// grants the port and records the two beats and the strobes around them
task automatic collect_beats(input string test, output bit ok);
    int n;
    cpk_tx_ack = 1'b1;
    @(negedge PCIE_CLK);
    cpk_tx_ack = 1'b0;
    ok = cpk_tx_dvld;
    for (n = 0; n < wait_limit && !ok; n++) begin
        @(negedge PCIE_CLK);
        ok = cpk_tx_dvld;
    end
    if (!ok) begin
        note_problem(test, "no beat appeared after cpk_tx_ack");
    end else begin
        sop_word  = cpk_tx_data;
        sop_ctl   = {cpk_tx_dvld, cpk_tx_sop, cpk_tx_eop, cpk_tx_mask};
        ok_at_sop = reg_rd_ok;
        @(negedge PCIE_CLK);                         // eop is the very next beat
        eop_word   = cpk_tx_data;
        eop_ctl    = {cpk_tx_dvld, cpk_tx_sop, cpk_tx_eop, cpk_tx_mask};
        ok_at_eop  = reg_rd_ok;
        req_at_eop = cpk_tx_req;
    end
endtask

task automatic run_completion(input string test, input logic [7:0] be, output bit ok);
    issue_read(test, be, ok);
    if (ok) collect_beats(test, ok);
endtask

// ======================================================================
// directed tests
// ======================================================================
task automatic reset_idle();
    logic [63:0] ctl;
    int          n;
    for (n = 0; n < 10; n++) begin
        @(negedge PCIE_CLK);
        ctl = {57'd0, cpk_tx_req, cpk_tx_dvld, cpk_tx_sop, cpk_tx_eop, cpk_tx_mask, reg_rd_ok};
        if (ctl !== 64'd0) report_mismatch("reset_idle", "strobes", 64'd0, ctl);
        if (cpk_tx_data !== 64'd0) report_mismatch("reset_idle", "data", 64'd0, cpk_tx_data);
    end
    finish_test("reset_idle");
endtask

task automatic full_completion();
    bit ok;
    run_completion("full_completion", 8'h0f, ok);
    if (ok) begin
        if (sop_word !== sop_expected())
            report_mismatch("full_completion", "sop beat", sop_expected(), sop_word);
        if (sop_ctl !== 5'b11011)                    // dvld, sop, mask 11
            report_mismatch("full_completion", "sop flags", 64'h1b, {59'd0, sop_ctl});
        if (eop_word !== eop_expected())
            report_mismatch("full_completion", "eop beat", eop_expected(), eop_word);
        if (eop_ctl !== 5'b10111)                    // dvld, eop, mask 11
            report_mismatch("full_completion", "eop flags", 64'h17, {59'd0, eop_ctl});
    end
    finish_test("full_completion");
endtask

task automatic be_decode_sweep();
    bit         ok;
    int         b;
    logic [3:0] be4;
    for (b = 0; b < 16; b++) begin
        be4 = b[3:0];
        run_completion("be_decode_sweep", {4'h0, be4}, ok);
        if (ok && sop_word[43:32] !== byte_count_for(be4))
            report_mismatch("be_decode_sweep", "byte count",
                            {52'd0, byte_count_for(be4)}, {52'd0, sop_word[43:32]});
        if (ok && eop_word[6:0] !== low_addr_for(be4, reg_op_addr))
            report_mismatch("be_decode_sweep", "low address",
                            {57'd0, low_addr_for(be4, reg_op_addr)}, {57'd0, eop_word[6:0]});
    end
    finish_test("be_decode_sweep");
endtask

task automatic done_with_eop();
    bit ok;
    run_completion("done_with_eop", 8'h0f, ok);
    if (ok) begin
        if (ok_at_sop !== 1'b0)
            report_mismatch("done_with_eop", "ok at sop", 64'd0, {63'd0, ok_at_sop});
        if (eop_ctl[2] !== 1'b1) note_problem("done_with_eop", "second beat is not an eop");
        if (ok_at_eop !== 1'b1)
            report_mismatch("done_with_eop", "ok at eop", 64'd1, {63'd0, ok_at_eop});
        if (req_at_eop !== 1'b0) note_problem("done_with_eop", "cpk_tx_req still high at eop");
        @(negedge PCIE_CLK);
        if (reg_rd_ok !== 1'b0) note_problem("done_with_eop", "reg_rd_ok longer than one cycle");
        if (cpk_tx_req !== 1'b0) note_problem("done_with_eop", "cpk_tx_req high after eop");
    end
    finish_test("done_with_eop");
endtask

task automatic backpressure_hold();
    bit ok;
    int n;
    int beats;
    issue_read("backpressure_hold", 8'h0f, ok);
    if (ok) begin
        for (n = 0; n < 30; n++) begin               // grant withheld
            @(negedge PCIE_CLK);
            if (cpk_tx_req !== 1'b1) note_problem("backpressure_hold", "cpk_tx_req dropped");
            if (cpk_tx_dvld !== 1'b0) note_problem("backpressure_hold", "beat sent without grant");
        end
        cpk_tx_ack = 1'b1;
        @(negedge PCIE_CLK);
        cpk_tx_ack = 1'b0;
        beats = 0;
        for (n = 0; n < 8; n++) begin                // window well past the eop
            if (cpk_tx_dvld === 1'b1) beats++;
            @(negedge PCIE_CLK);
        end
        if (beats != 2) report_mismatch("backpressure_hold", "beat count", 64'd2, 64'(beats));
    end
    finish_test("backpressure_hold");
endtask

`endif

//--- dv/tb_pcie_reg_ack.sv
// runs at the default of 2 ack stages; inputs change and outputs are sampled on the falling edge
module tb_pcie_reg_ack;

    logic        PCIE_CLK = 1'b0;
    logic        PCIE_RST;
    logic        reg_rd_req;
    logic        reg_rd_ack;
    logic [31:0] reg_rd_data;
    logic [63:0] reg_op_addr;
    logic        reg_rd_ok;
    logic [2:0]  rx_tc;
    logic        rx_td;
    logic        rx_ep;
    logic [1:0]  rx_attr;
    logic [9:0]  rx_len;
    logic [15:0] rx_rid;
    logic [7:0]  rx_rtag;
    logic [7:0]  rx_be;
    logic [15:0] completer_id;
    logic        cpk_tx_req;
    logic        cpk_tx_ack;
    logic [63:0] cpk_tx_data;
    logic [1:0]  cpk_tx_mask;
    logic        cpk_tx_dvld;
    logic        cpk_tx_sop;
    logic        cpk_tx_eop;

    integer      seed = 32'hfb30;                    // fixed random seed
    int          test_errs = 0;                      // errors in the running test
    int          tests_run = 0;
    int          tests_failed = 0;
    logic [63:0] sop_word;                           // captured first beat
    logic [63:0] eop_word;                           // captured last beat
    logic [4:0]  sop_ctl;                            // dvld, sop, eop, mask
    logic [4:0]  eop_ctl;
    logic        ok_at_sop;
    logic        ok_at_eop;
    logic        req_at_eop;

    always #10 PCIE_CLK = ~PCIE_CLK;                 // period 20

    pcie_reg_ack #(.ACK_SYNC_STAGES(2)) dut0 (.*);

    // ======================================================================
    // reference model from the completion rules
    // ======================================================================
    function automatic logic [11:0] byte_count_for(input logic [3:0] be);
        if (be[3] && be[0]) return 12'd4;            // 1xx1
        if ((!be[3] && be[2] && be[0]) || (be[3] && be[1] && !be[0])) return 12'd3;
        if (be == 4'b0011 || be == 4'b0110 || be == 4'b1100) return 12'd2;
        return 12'd1;                                // includes 0000
    endfunction

    function automatic logic [6:0] low_addr_for(input logic [3:0] be, input logic [63:0] addr);
        logic [1:0] lo;
        if (be == 4'b0000 || be[0]) lo = 2'd0;
        else if (be[1]) lo = 2'd1;
        else if (be[2]) lo = 2'd2;
        else lo = 2'd3;
        return {addr[6:2], lo};
    endfunction

    function automatic logic [31:0] swap_bytes(input logic [31:0] d);
        return {d[7:0], d[15:8], d[23:16], d[31:24]};
    endfunction

    // dw1 over dw0
    function automatic logic [63:0] sop_expected();
        return {completer_id, 3'b000, 1'b0, byte_count_for(rx_be[3:0]),
                1'b0, 7'b1001010, 1'b0, rx_tc, 4'b0000, rx_td, rx_ep, rx_attr, 2'b00, rx_len};
    endfunction

    // payload over dw2
    function automatic logic [63:0] eop_expected();
        return {swap_bytes(reg_rd_data), rx_rid, rx_rtag, 1'b0,
                low_addr_for(rx_be[3:0], reg_op_addr)};
    endfunction

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    task automatic report_mismatch(input string test, input string what,
                                   input logic [63:0] exp, input logic [63:0] act);
        $display("error %s %s expected %h actual %h", test, what, exp, act);
        test_errs++;
    endtask

    task automatic note_problem(input string test, input string what);
        $display("%s: %s", test, what);
        test_errs++;
    endtask

    task automatic finish_test(input string test);
        tests_run++;
        if (test_errs == 0) begin
            $display("%s passed", test);
        end else begin
            $display("%s failed with %0d errors", test, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    `include "pcie_reg_ack_tests.svh"

    // ======================================================================
    // test sequence
    // ======================================================================
    initial begin
        PCIE_RST     = 1'b1;
        reg_rd_req   = 1'b0;
        reg_rd_ack   = 1'b0;
        reg_rd_data  = 32'd0;
        reg_op_addr  = 64'd0;
        rx_tc        = 3'd0;
        rx_td        = 1'b0;
        rx_ep        = 1'b0;
        rx_attr      = 2'd0;
        rx_len       = 10'd0;
        rx_rid       = 16'd0;
        rx_rtag      = 8'd0;
        rx_be        = 8'd0;
        completer_id = 16'd0;
        cpk_tx_ack   = 1'b0;
        repeat (4) @(posedge PCIE_CLK);              // reset for 4 cycles
        @(negedge PCIE_CLK);
        PCIE_RST = 1'b0;

        reset_idle();
        full_completion();
        be_decode_sweep();
        done_with_eop();
        backpressure_hold();

        $display("tests run %0d passed %0d failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
design/pcie_cpl_pkg.sv
design/cpl_req_capture.sv
design/cpl_hdr_build.sv
design/cpl_tx_seq.sv
design/pcie_reg_ack.sv
dv/tb_pcie_reg_ack.sv
